/* Makefile */
# Verilator build and run of the multiply/divide unit testbench

SOURCES := $(filter %.sv,$(shell cat project.f))

obj_dir/VmulDivTb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module mulDivTb \
		-f project.f -o VmulDivTb

# Passes only when the pass line shows up in the simulator output
run: obj_dir/VmulDivTb
	@out="$$(./obj_dir/VmulDivTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* bench/clockGen.sv */
/*
 * Testbench clock and synchronous reset source
 */

`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rstN
);

	// 40 ns period
	localparam int halfPeriod = 20;
	localparam int resetCycles = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk;
	end

	// Reset is released on a falling edge, well away from the sampling edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles)
			@(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

/* bench/mulDivTb.sv */
/*
 * Directed tests for the multiply/divide unit: reference model,
 * per-test tasks, latency and back-pressure checks, final report
 */

`timescale 1ns/1ps

module mulDivTb;

	localparam int dw = mulDivOpsPkg::dataWidth;
	localparam int respTimeout = 100;
	localparam int resetTimeout = 40;
	// Edges from the request transfer to the edge that raises rspValid
	localparam int mulLatency = mulDivOpsPkg::mulStages + 3;
	localparam int divLatency = mulDivOpsPkg::divSteps + 3;

	logic clk, rstN;
	mulDivBusPkg::MdReq req;
	logic reqValid, reqReady;
	mulDivBusPkg::MdRsp rsp;
	logic rspValid, rspReady;

	integer seed;
	int errors, checks, testErrors, testsRun, testsFailed;
	// Set once the DUT stops answering so later operations are skipped
	bit stalled;

	clockGen clockGen_inst (
		.clk(clk),
		.rstN(rstN)
	);

	mulDivUnit mulDivUnit_inst (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.rspReady(rspReady)
	);

	// ==============================
	// Reference model
	// ==============================

	// Works on 64-bit values so every true product and quotient fits
	function automatic mulDivBusPkg::MdRsp expectedRsp(
		input mulDivOpsPkg::MdOp op,
		input logic [dw-1:0] a,
		input logic [dw-1:0] b,
		input logic [dw-1:0] c
	);
		mulDivBusPkg::MdRsp want;
		logic signed [63:0] sa, sb, ua, ub, prod;
		sa = {{dw{a[dw-1]}}, a};
		sb = {{dw{b[dw-1]}}, b};
		ua = {{dw{1'b0}}, a};
		ub = {{dw{1'b0}}, b};
		want = '0;
		prod = sa * sb;
		if (op == mulDivOpsPkg::MUL_HU)
			prod = ua * ub;
		else if (op == mulDivOpsPkg::MUL_HSU)
			prod = sa * ub;
		want.result = prod[63:32];
		// Signed forms overflow unless the high half copies the low sign bit
		want.overflow = prod[63:32] != {dw{prod[31]}};
		case (op)
			mulDivOpsPkg::MUL_ADD:
				want.result = prod[31:0] + c;
			mulDivOpsPkg::MUL_HU:
				want.overflow = prod[63:32] != '0;
			mulDivOpsPkg::DIV:
				want.result = 32'(sa / sb);
			mulDivOpsPkg::DIVU:
				want.result = 32'(ua / ub);
			mulDivOpsPkg::REM:
				want.result = 32'(sa % sb);
			mulDivOpsPkg::REMU:
				want.result = 32'(ua % ub);
			default:
				want.result = prod[63:32];
		endcase
		if (!(op inside {mulDivOpsPkg::MUL_ADD, mulDivOpsPkg::MUL_H,
			mulDivOpsPkg::MUL_HU, mulDivOpsPkg::MUL_HSU}))
		begin
			want.overflow = 1'b0;
			// Zero divisor gives all ones or the dividend back for either sign
			if (b == '0)
			begin
				want.divByZero = 1'b1;
				want.result = (op == mulDivOpsPkg::DIV || op == mulDivOpsPkg::DIVU) ? '1 : a;
			end
		end
		return want;
	endfunction

	// ==============================
	// Transaction helpers
	// ==============================

	// Sends one request, waits for the response and takes it after holdCycles
	task automatic runOp(input mulDivOpsPkg::MdOp op, input logic [dw-1:0] a,
		input logic [dw-1:0] b, input logic [dw-1:0] c, input int holdCycles,
		output mulDivBusPkg::MdRsp got, output int cycles);
		int waitCnt;
		bit earlyReady;
		waitCnt = 0;
		earlyReady = 1'b0;
		got = '0;
		cycles = 0;
		if (stalled)
			return;
		@(negedge clk);
		req.op = op;
		req.a = a;
		req.b = b;
		req.c = c;
		reqValid = 1'b1;
		while (!reqReady && waitCnt < respTimeout)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (!reqReady)
		begin
			$display("The DUT never accepted the %s request", op.name());
			reqValid = 1'b0;
			stalled = 1'b1;
			testErrors++;
			return;
		end
		// Transfer edge lies between these two falling edges
		@(negedge clk);
		reqValid = 1'b0;
		cycles = 0;
		while (!rspValid && cycles < respTimeout)
		begin
			if (reqReady)
				earlyReady = 1'b1;
			@(negedge clk);
			cycles++;
		end
		if (!rspValid)
		begin
			$display("The DUT gave no response to %s within %0d cycles", op.name(), cycles);
			stalled = 1'b1;
			testErrors++;
			return;
		end
		got = rsp;
		checks++;
		if (earlyReady)
		begin
			testErrors++;
			$display("ERROR at %0t: reqReady rose before the %s response", $time, op.name());
		end
		// Response must sit still while the consumer stalls
		repeat (holdCycles)
		begin
			@(negedge clk);
			checks++;
			if (rsp !== got || rspValid !== 1'b1 || reqReady !== 1'b0)
			begin
				testErrors++;
				$display("ERROR at %0t: response or handshake moved under back-pressure",
					$time);
			end
		end
		rspReady = 1'b1;
		@(negedge clk);
		rspReady = 1'b0;
	endtask

	// One operation against the reference model and the fixed latency
	task automatic checkOp(input mulDivOpsPkg::MdOp op, input logic [dw-1:0] a,
		input logic [dw-1:0] b, input logic [dw-1:0] c, input int holdCycles);
		mulDivBusPkg::MdRsp got, want;
		int cycles, wantCycles;
		want = expectedRsp(op, a, b, c);
		wantCycles = (op inside {mulDivOpsPkg::MUL_ADD, mulDivOpsPkg::MUL_H,
			mulDivOpsPkg::MUL_HU, mulDivOpsPkg::MUL_HSU}) ? mulLatency : divLatency;
		runOp(op, a, b, c, holdCycles, got, cycles);
		if (stalled)
			return;
		checks++;
		if (got !== want)
		begin
			testErrors++;
			$display("ERROR at %0t: %s a=%h b=%h c=%h gave %h ovf %b dbz %b, expected %h %b %b",
				$time, op.name(), a, b, c, got.result, got.overflow, got.divByZero,
				want.result, want.overflow, want.divByZero);
		end
		checks++;
		if (cycles != wantCycles)
		begin
			testErrors++;
			$display("ERROR at %0t: %s answered after %0d cycles, expected %0d",
				$time, op.name(), cycles, wantCycles);
		end
	endtask

	task automatic reportTest(input string name);
		testsRun++;
		errors += testErrors;
		if (testErrors == 0)
			$display("Test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("Test %s: %0d errors", name, testErrors);
		end
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic checkResetState();
		testErrors = 0;
		@(negedge clk);
		checks++;
		if (reqReady !== 1'b1 || rspValid !== 1'b0)
		begin
			testErrors++;
			$display("ERROR at %0t: after reset reqReady=%b rspValid=%b, expected 1 and 0",
				$time, reqReady, rspValid);
		end
		reportTest("reset state");
	endtask

	task automatic multiplyOps();
		logic [dw-1:0] a, b, c;
		testErrors = 0;
		// Max positive times 2 spills into the high half while 3 times 4 does not
		checkOp(mulDivOpsPkg::MUL_ADD, 32'h7fff_ffff, 32'd2, 32'd5, 0);
		checkOp(mulDivOpsPkg::MUL_H, 32'h7fff_ffff, 32'd2, '0, 0);
		checkOp(mulDivOpsPkg::MUL_ADD, 32'd3, 32'd4, 32'h1000_0000, 0);
		checkOp(mulDivOpsPkg::MUL_H, 32'd3, 32'd4, '0, 0);
		checkOp(mulDivOpsPkg::MUL_H, 32'h8000_0000, 32'h8000_0000, '0, 0);
		checkOp(mulDivOpsPkg::MUL_H, 32'hffff_fffd, 32'd5, '0, 0);
		checkOp(mulDivOpsPkg::MUL_HU, 32'hffff_ffff, 32'hffff_ffff, '0, 0);
		checkOp(mulDivOpsPkg::MUL_HSU, 32'hffff_ffff, 32'hffff_ffff, '0, 0);
		checkOp(mulDivOpsPkg::MUL_HSU, 32'h8000_0000, 32'hffff_ffff, '0, 0);
		for (int i = 0; i < 4; i++)
		begin
			for (int n = 0; n < 6; n++)
			begin
				a = $random(seed);
				b = $random(seed);
				c = $random(seed);
				checkOp(mulDivOpsPkg::MdOp'(i), a, b, c, 0);
			end
		end
		reportTest("multiply");
	endtask

	task automatic divideOps();
		logic [dw-1:0] a, b;
		testErrors = 0;
		// Most negative over minus one wraps back to itself with remainder zero
		checkOp(mulDivOpsPkg::DIV, 32'h8000_0000, 32'hffff_ffff, '0, 0);
		checkOp(mulDivOpsPkg::REM, 32'h8000_0000, 32'hffff_ffff, '0, 0);
		checkOp(mulDivOpsPkg::DIVU, 32'h8000_0000, 32'hffff_ffff, '0, 0);
		checkOp(mulDivOpsPkg::DIV, -32'sd7, 32'd2, '0, 0);
		checkOp(mulDivOpsPkg::REM, -32'sd7, 32'd2, '0, 0);
		checkOp(mulDivOpsPkg::DIV, 32'd7, -32'sd2, '0, 0);
		checkOp(mulDivOpsPkg::REM, 32'd7, -32'sd2, '0, 0);
		checkOp(mulDivOpsPkg::REM, -32'sd7, -32'sd2, '0, 0);
		for (int i = 4; i < 8; i++)
		begin
			for (int n = 0; n < 6; n++)
			begin
				a = $random(seed);
				b = $random(seed);
				// Odd sizes of divisor exercise short and long quotients
				if (n[0])
					b = b >>> (n * 4);
				if (b == '0)
					b = 32'd1;
				checkOp(mulDivOpsPkg::MdOp'(i), a, b, '0, 0);
			end
		end
		reportTest("divide");
	endtask

	task automatic divideByZero();
		logic [dw-1:0] a;
		testErrors = 0;
		for (int i = 4; i < 8; i++)
		begin
			a = $random(seed);
			checkOp(mulDivOpsPkg::MdOp'(i), a, '0, '0, 0);
			checkOp(mulDivOpsPkg::MdOp'(i), a | 32'h8000_0000, '0, '0, 0);
		end
		reportTest("divide by zero");
	endtask

	task automatic backPressure();
		testErrors = 0;
		checkOp(mulDivOpsPkg::MUL_HSU, 32'hdead_beef, 32'h1234_5678, '0, 5);
		checkOp(mulDivOpsPkg::MUL_ADD, 32'hffff_fff0, 32'd9, 32'd100, 2);
		checkOp(mulDivOpsPkg::REM, 32'hcafe_f00d, 32'd97, '0, 4);
		checkOp(mulDivOpsPkg::DIV, 32'h8765_4321, '0, '0, 3);
		reportTest("latency and back-pressure");
	endtask

	// ==============================
	// Sequence and report
	// ==============================

	initial
	begin
		int waitCnt;
		seed = 32'hc879_59a7;
		req = '0;
		reqValid = 1'b0;
		rspReady = 1'b0;
		errors = 0;
		checks = 0;
		testsRun = 0;
		testsFailed = 0;
		stalled = 1'b0;
		waitCnt = 0;
		while (rstN !== 1'b1 && waitCnt < resetTimeout)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (rstN !== 1'b1)
		begin
			$display("Reset was never released");
			stalled = 1'b1;
			errors++;
		end
		checkResetState();
		multiplyOps();
		divideOps();
		divideByZero();
		backPressure();
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* bench/mulDiv_assertions.sv */
/*
 * Concurrent checks on the controller handshake and its reset state
 */

`timescale 1ns/1ps

module mulDiv_assertions (
	input logic clk,
	input logic rstN,
	input logic reqReady,
	input logic rspValid,
	input logic rspReady,
	input mulDivBusPkg::MdRsp rsp
);

	// ==============================
	// Handshake
	// ==============================

	// The request side is never open together with the response side
	// It reopens only right after the edge that takes the response
	noOverlap: assert property (@(posedge clk) disable iff (!rstN)
		!(reqReady && rspValid) && (!$rose(reqReady) || $past(rspValid && rspReady)))
		else $error("reqReady high with rspValid or before the response was taken");

	// A response that is not taken keeps its data
	rspHold: assert property (@(posedge clk) disable iff (!rstN)
		rspValid && !rspReady |=> $stable(rsp))
		else $error("rsp changed while rspReady was low");

	// ==============================
	// Reset
	// ==============================

	// Nothing to send straight out of reset
	resetQuiet: assert property (@(posedge clk) !rstN |=> !rspValid)
		else $error("rspValid high in the cycle after reset");

endmodule

// Every controller instance gets the checks
bind mulDivCtrl mulDiv_assertions mulDivAssertions_inst (
	.clk(clk),
	.rstN(rstN),
	.reqReady(reqReady),
	.rspValid(rspValid),
	.rspReady(rspReady),
	.rsp(rsp)
);

/* logic/divUnit.sv */
/*
 * Iterative unsigned restoring divider, one quotient bit per clock,
 * with a single-cycle done pulse and a divide-by-zero flag
 */

`timescale 1ns/1ps

module divUnit (
	input  logic clk,
	input  logic rstN,
	input  logic load,
	input  logic [mulDivOpsPkg::dataWidth-1:0] dividend,
	input  logic [mulDivOpsPkg::dataWidth-1:0] divisor,
	output logic [mulDivOpsPkg::dataWidth-1:0] quotient,
	output logic [mulDivOpsPkg::dataWidth-1:0] remainder,
	output logic divByZero,
	output logic done
);

	localparam int dw = mulDivOpsPkg::dataWidth;

	logic [dw-1:0] remReg, quoReg, divReg;
	logic [mulDivOpsPkg::cntWidth-1:0] count;
	logic busy;
	logic [dw:0] shifted, diff;
	logic fits;

	// ==============================
	// One restoring step
	// ==============================

	// The quotient register starts as the dividend and empties from the top
	// while quotient bits fill in from the bottom
	assign shifted = {remReg, quoReg[dw-1]};
	assign diff = shifted - {1'b0, divReg};

	// A non-negative trial difference means the divisor fits
	// With a zero divisor it always fits, giving all ones and the dividend back
	assign fits = !diff[dw];

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			remReg <= '0;
			quoReg <= dividend;
			divReg <= divisor;
		end
		else if (busy)
		begin
			remReg <= fits ? diff[dw-1:0] : shifted[dw-1:0];
			quoReg <= {quoReg[dw-2:0], fits};
		end
	end

	// ==============================
	// Sequencing
	// ==============================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
			divByZero <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (load)
			begin
				busy <= 1'b1;
				count <= mulDivOpsPkg::cntWidth'(mulDivOpsPkg::divSteps);
				// Flagged now, but the full count still runs
				divByZero <= divisor == '0;
			end
			else if (busy)
			begin
				count <= count - 1'b1;
				// Last step lands this edge
				if (count == 1)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Results stay put until the next load
	assign quotient = quoReg;
	assign remainder = remReg;

endmodule

/* logic/mulDivBusPkg.sv */
/*
 * Request and response structures carried on the ports of the
 * multiply/divide unit
 */

package mulDivBusPkg;

	// ==============================
	// Request side
	// ==============================

	// One operation with its two sources and the addend
	// The addend is only used by MUL_ADD
	typedef struct packed {
		mulDivOpsPkg::MdOp op;
		logic [mulDivOpsPkg::dataWidth-1:0] a;
		logic [mulDivOpsPkg::dataWidth-1:0] b;
		logic [mulDivOpsPkg::dataWidth-1:0] c;
	} MdReq;

	// ==============================
	// Response side
	// ==============================

	// Result word plus the two status flags
	// Overflow only has meaning for multiplies, divByZero only for divides
	typedef struct packed {
		logic [mulDivOpsPkg::dataWidth-1:0] result;
		logic overflow;
		logic divByZero;
	} MdRsp;

endpackage

/* logic/mulDivCtrl.sv */
/*
 * Multiply/divide controller: request handshake, operand sign
 * conditioning, datapath launch, result fix-up and response
 */

`timescale 1ns/1ps

module mulDivCtrl (
	input  logic clk,
	input  logic rstN,
	input  mulDivBusPkg::MdReq req,
	input  logic reqValid,
	output logic reqReady,
	output mulDivBusPkg::MdRsp rsp,
	output logic rspValid,
	input  logic rspReady,
	output logic mulInValid,
	output logic [mulDivOpsPkg::dataWidth-1:0] mulA,
	output logic [mulDivOpsPkg::dataWidth-1:0] mulB,
	input  logic mulOutValid,
	input  logic [mulDivOpsPkg::prodWidth-1:0] mulProduct,
	output logic divLoad,
	output logic [mulDivOpsPkg::dataWidth-1:0] dividend,
	output logic [mulDivOpsPkg::dataWidth-1:0] divisor,
	input  logic [mulDivOpsPkg::dataWidth-1:0] quotient,
	input  logic [mulDivOpsPkg::dataWidth-1:0] remainder,
	input  logic divByZero,
	input  logic divDone
);

	mulDivOpsPkg::CtrlState state, nextState;
	mulDivBusPkg::MdReq reqReg;
	mulDivBusPkg::MdRsp fixRsp;
	logic [mulDivOpsPkg::dataWidth-1:0] magA, magB;
	logic [mulDivOpsPkg::prodWidth-1:0] prodReg, signedProd;
	logic [mulDivOpsPkg::dataWidth-1:0] prodLo, prodHi;
	logic setupNeg, setupIsMul, resNeg;

	// Two's complement magnitude of a word
	function automatic logic [mulDivOpsPkg::dataWidth-1:0] magnitude(
		input logic [mulDivOpsPkg::dataWidth-1:0] v
	);
		return v[mulDivOpsPkg::dataWidth-1] ? -v : v;
	endfunction

	// ==============================
	// Sign conditioning in SETUP
	// ==============================

	// The multiplier and divider are both unsigned
	// Signed forms feed them magnitudes and remember the sign of the result
	always_comb
	begin
		magA = reqReg.a;
		magB = reqReg.b;
		setupNeg = 1'b0;
		setupIsMul = 1'b0;
		case (reqReg.op)
			mulDivOpsPkg::MUL_ADD, mulDivOpsPkg::MUL_H:
			begin
				magA = magnitude(reqReg.a);
				magB = magnitude(reqReg.b);
				setupNeg = reqReg.a[mulDivOpsPkg::dataWidth-1] ^
					reqReg.b[mulDivOpsPkg::dataWidth-1];
				setupIsMul = 1'b1;
			end
			// Only the first source is signed here
			mulDivOpsPkg::MUL_HSU:
			begin
				magA = magnitude(reqReg.a);
				setupNeg = reqReg.a[mulDivOpsPkg::dataWidth-1];
				setupIsMul = 1'b1;
			end
			mulDivOpsPkg::MUL_HU:
				setupIsMul = 1'b1;
			// Quotient sign is the XOR of both operand signs
			mulDivOpsPkg::DIV:
			begin
				magA = magnitude(reqReg.a);
				magB = magnitude(reqReg.b);
				setupNeg = reqReg.a[mulDivOpsPkg::dataWidth-1] ^
					reqReg.b[mulDivOpsPkg::dataWidth-1];
			end
			// Remainder follows the dividend
			mulDivOpsPkg::REM:
			begin
				magA = magnitude(reqReg.a);
				magB = magnitude(reqReg.b);
				setupNeg = reqReg.a[mulDivOpsPkg::dataWidth-1];
			end
			default:
				setupNeg = 1'b0;
		endcase
	end

	// The divider samples its operands straight out of SETUP
	assign divLoad = (state == mulDivOpsPkg::SETUP) && !setupIsMul;
	assign dividend = magA;
	assign divisor = magB;

	// ==============================
	// Result fix-up in FIX
	// ==============================

	assign signedProd = resNeg ? -prodReg : prodReg;
	assign prodLo = signedProd[mulDivOpsPkg::dataWidth-1:0];
	assign prodHi = signedProd[mulDivOpsPkg::prodWidth-1:mulDivOpsPkg::dataWidth];

	always_comb
	begin
		fixRsp.result = prodHi;
		fixRsp.divByZero = 1'b0;
		// Signed forms overflow when the high half is not the low half's sign extension
		fixRsp.overflow = prodHi != {mulDivOpsPkg::dataWidth{prodLo[mulDivOpsPkg::dataWidth-1]}};
		case (reqReg.op)
			// Addend goes onto the low half, overflow is judged before it
			mulDivOpsPkg::MUL_ADD:
				fixRsp.result = prodLo + reqReg.c;
			mulDivOpsPkg::MUL_HU:
				fixRsp.overflow = prodHi != '0;
			// A zero divisor keeps the all-ones quotient from the divider
			mulDivOpsPkg::DIV, mulDivOpsPkg::DIVU:
			begin
				fixRsp.result = (resNeg && !divByZero) ? -quotient : quotient;
				fixRsp.overflow = 1'b0;
				fixRsp.divByZero = divByZero;
			end
			mulDivOpsPkg::REM, mulDivOpsPkg::REMU:
			begin
				fixRsp.result = resNeg ? -remainder : remainder;
				fixRsp.overflow = 1'b0;
				fixRsp.divByZero = divByZero;
			end
			default:
				fixRsp.result = prodHi;
		endcase
	end

	// ==============================
	// State machine
	// ==============================

	always_comb
	begin
		nextState = state;
		case (state)
			mulDivOpsPkg::IDLE:
				if (reqValid)
					nextState = mulDivOpsPkg::SETUP;
			mulDivOpsPkg::SETUP:
				nextState = setupIsMul ? mulDivOpsPkg::MUL_WAIT : mulDivOpsPkg::DIV_WAIT;
			mulDivOpsPkg::MUL_WAIT:
				if (mulOutValid)
					nextState = mulDivOpsPkg::FIX;
			mulDivOpsPkg::DIV_WAIT:
				if (divDone)
					nextState = mulDivOpsPkg::FIX;
			mulDivOpsPkg::FIX:
				nextState = mulDivOpsPkg::RESPOND;
			mulDivOpsPkg::RESPOND:
				if (rspReady)
					nextState = mulDivOpsPkg::IDLE;
			default:
				nextState = mulDivOpsPkg::IDLE;
		endcase
	end

	// The multiplier launch is registered, so it fires in the first MUL_WAIT cycle
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= mulDivOpsPkg::IDLE;
			mulInValid <= 1'b0;
		end
		else
		begin
			state <= nextState;
			mulInValid <= (state == mulDivOpsPkg::SETUP) && setupIsMul;
		end
	end

	// Request, operands, product and response words
	always_ff @(posedge clk)
	begin
		if (state == mulDivOpsPkg::IDLE && reqValid)
			reqReg <= req;
		if (state == mulDivOpsPkg::SETUP)
		begin
			resNeg <= setupNeg;
			mulA <= magA;
			mulB <= magB;
		end
		if (state == mulDivOpsPkg::MUL_WAIT && mulOutValid)
			prodReg <= mulProduct;
		// Response holds from here through any back-pressure
		if (state == mulDivOpsPkg::FIX)
			rsp <= fixRsp;
	end

	assign reqReady = state == mulDivOpsPkg::IDLE;
	assign rspValid = state == mulDivOpsPkg::RESPOND;

endmodule

/* logic/mulDivOpsPkg.sv */
/*
 * Operation and controller state encodings, datapath widths,
 * multiplier stage count and divider step count
 */

package mulDivOpsPkg;

	// ==============================
	// Datapath sizing
	// ==============================

	// Operand and result word width
	localparam int dataWidth = 32;

	// The multiplier splits each operand into two halves of this width
	localparam int halfWidth = dataWidth / 2;

	// Full width of an unsigned product
	localparam int prodWidth = 2 * dataWidth;

	// Register stages between the multiplier input and its product
	localparam int mulStages = 4;

	// One quotient bit per divider iteration
	localparam int divSteps = dataWidth;

	// Iteration counter must hold divSteps itself
	localparam int cntWidth = $clog2(divSteps + 1);

	// ==============================
	// Encodings
	// ==============================

	// Operations arrive already decoded from the instruction
	typedef enum logic [2:0] {
		MUL_ADD = 3'd0,
		MUL_H   = 3'd1,
		MUL_HU  = 3'd2,
		MUL_HSU = 3'd3,
		DIV     = 3'd4,
		DIVU    = 3'd5,
		REM     = 3'd6,
		REMU    = 3'd7
	} MdOp;

	// Controller sequence, one request at a time
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		SETUP    = 3'd1,
		MUL_WAIT = 3'd2,
		DIV_WAIT = 3'd3,
		FIX      = 3'd4,
		RESPOND  = 3'd5
	} CtrlState;

endpackage

/* logic/mulDivUnit.sv */
/*
 * Multiply/divide unit top: controller, pipelined multiplier
 * and iterative divider
 */

`timescale 1ns/1ps

module mulDivUnit (
	input  logic clk,
	input  logic rstN,
	input  mulDivBusPkg::MdReq req,
	input  logic reqValid,
	output logic reqReady,
	output mulDivBusPkg::MdRsp rsp,
	output logic rspValid,
	input  logic rspReady
);

	// Multiplier side
	logic mulInValid, mulOutValid;
	logic [mulDivOpsPkg::dataWidth-1:0] mulA, mulB;
	logic [mulDivOpsPkg::prodWidth-1:0] mulProduct;

	// Divider side
	logic divLoad, divByZero, divDone;
	logic [mulDivOpsPkg::dataWidth-1:0] dividend, divisor;
	logic [mulDivOpsPkg::dataWidth-1:0] quotient, remainder;

	// ==============================
	// Controller
	// ==============================

	mulDivCtrl mulDivCtrl_inst (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.mulInValid(mulInValid),
		.mulA(mulA),
		.mulB(mulB),
		.mulOutValid(mulOutValid),
		.mulProduct(mulProduct),
		.divLoad(divLoad),
		.dividend(dividend),
		.divisor(divisor),
		.quotient(quotient),
		.remainder(remainder),
		.divByZero(divByZero),
		.divDone(divDone)
	);

	// ==============================
	// Datapath
	// ==============================

	mulPipe mulPipe_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(mulInValid),
		.a(mulA),
		.b(mulB),
		.outValid(mulOutValid),
		.product(mulProduct)
	);

	divUnit divUnit_inst (
		.clk(clk),
		.rstN(rstN),
		.load(divLoad),
		.dividend(dividend),
		.divisor(divisor),
		.quotient(quotient),
		.remainder(remainder),
		.divByZero(divByZero),
		.done(divDone)
	);

endmodule

/* logic/mulPipe.sv */
/*
 * Four-stage unsigned 32x32 multiplier built from 16-bit partial
 * products, with a valid bit moving along with the data
 */

`timescale 1ns/1ps

module mulPipe (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  logic [mulDivOpsPkg::dataWidth-1:0] a,
	input  logic [mulDivOpsPkg::dataWidth-1:0] b,
	output logic outValid,
	output logic [mulDivOpsPkg::prodWidth-1:0] product
);

	localparam int hw = mulDivOpsPkg::halfWidth;
	localparam int dw = mulDivOpsPkg::dataWidth;

	logic [mulDivOpsPkg::mulStages-1:0] validPipe;
	logic [dw-1:0] s1Ll, s1Lh, s1Hl, s1Hh;
	logic [dw-1:0] s2Ll, s2Hh;
	logic [dw:0] s2Mid;
	logic [dw:0] s3Low;
	logic [hw:0] s3MidHi;
	logic [dw-1:0] s3Hh;

	// ==============================
	// Arithmetic stages
	// ==============================

	always_ff @(posedge clk)
	begin
		// Stage 1 forms the four half-by-half partial products
		s1Ll <= a[hw-1:0] * b[hw-1:0];
		s1Lh <= a[hw-1:0] * b[dw-1:hw];
		s1Hl <= a[dw-1:hw] * b[hw-1:0];
		s1Hh <= a[dw-1:hw] * b[dw-1:hw];
		// Stage 2 merges the two cross terms, which carry one extra bit
		s2Ll <= s1Ll;
		s2Hh <= s1Hh;
		s2Mid <= {1'b0, s1Lh} + {1'b0, s1Hl};
		// Stage 3 settles the low word and keeps its carry
		s3Low <= {1'b0, s2Ll} + {1'b0, s2Mid[hw-1:0], {hw{1'b0}}};
		s3MidHi <= s2Mid[dw:hw];
		s3Hh <= s2Hh;
		// Stage 4 folds the upper cross bits and the carry into the high word
		product <= {s3Hh + {{(hw-1){1'b0}}, s3MidHi} + {{(dw-1){1'b0}}, s3Low[dw]},
			s3Low[dw-1:0]};
	end

	// ==============================
	// Valid tracking
	// ==============================

	always_ff @(posedge clk)
	begin
		if (!rstN)
			validPipe <= '0;
		else
			validPipe <= {validPipe[mulDivOpsPkg::mulStages-2:0], inValid};
	end

	assign outValid = validPipe[mulDivOpsPkg::mulStages-1];

endmodule

/* project.f */
logic/mulDivOpsPkg.sv
logic/mulDivBusPkg.sv
logic/mulDivCtrl.sv
logic/mulPipe.sv
logic/divUnit.sv
logic/mulDivUnit.sv
bench/clockGen.sv
bench/mulDiv_assertions.sv
bench/mulDivTb.sv
